// File: rtl/exec_consts.svh
// ####################
// Width constants and the link register number
// ####################
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Data and address width
`define DATA_W 16

// Opcode field width, taken from the top of the instruction
`define OPC_W 5

// Register written by JAL and JALR
`define LINK_REG 7

`endif

// File: rtl/execPkg.sv
// ####################
// Opcode, ALU operation and immediate kind enums
// Stage input and result structs
// ####################
`include "exec_consts.svh"

package execPkg;

	// Opcodes handled by the execute stage
	typedef enum logic [`OPC_W-1:0] {
		NOP      = 5'b00001,
		J        = 5'b00100,
		JR       = 5'b00101,
		JAL      = 5'b00110,
		JALR     = 5'b00111,
		ADDI     = 5'b01000,
		SUBI     = 5'b01001,
		XORI     = 5'b01010,
		ANDNI    = 5'b01011,
		BEQZ     = 5'b01100,
		BNEZ     = 5'b01101,
		BLTZ     = 5'b01110,
		BGEZ     = 5'b01111,
		SLBI     = 5'b10010,
		ROLI     = 5'b10100,
		SLLI     = 5'b10101,
		RORI     = 5'b10110,
		SRLI     = 5'b10111,
		LBI      = 5'b11000,
		SHIFT_RR = 5'b11010,
		ALU_RR   = 5'b11011,
		SEQ      = 5'b11100,
		SLT      = 5'b11101,
		SLE      = 5'b11110
	} opcodeT;

	// Internal ALU operations after opcode and funct decode
	typedef enum logic [3:0] {
		opAdd, opSub, opXor, opAndn,
		opRol, opSll, opRor, opSrl,
		opEq, opLt, opLe,
		opPassB, opShiftLoad
	} aluOpT;

	// Immediate field formats
	typedef enum logic [2:0] {
		zero5, zero8, sign5, sign8, sign11
	} immKindT;

	// One instruction with its operands, 65 bits
	typedef struct packed {
		logic [`DATA_W-1:0] instr;
		logic [`DATA_W-1:0] regA;
		logic [`DATA_W-1:0] regB;
		// Fall-through address, PC+2
		logic [`DATA_W-1:0] pcNext;
		logic vld;
	} exInT;

	// Registered result toward the memory stage, 35 bits
	typedef struct packed {
		logic [`DATA_W-1:0] wbData;
		logic [`DATA_W-1:0] nextPc;
		logic taken;
		logic linkWrite;
		logic vld;
	} exResT;

endpackage

// File: rtl/immExtend.sv
// ####################
// Immediate field select and extension
// ####################
`timescale 1ns/1ps
`include "exec_consts.svh"

module immExtend (
	input  logic [`DATA_W-1:0] instr,
	output logic [`DATA_W-1:0] immValue
);
	import execPkg::*;

	opcodeT opc;
	immKindT immKind;

	assign opc = opcodeT'(instr[`DATA_W-1 -: `OPC_W]);

	// Format of the immediate for each opcode
	always_comb begin
		case (opc)
			// Logic immediates are unsigned
			XORI, ANDNI: immKind = zero5;
			SLBI: immKind = zero8;
			BEQZ, BNEZ, BLTZ, BGEZ, LBI, JR, JALR: immKind = sign8;
			// Long displacement of J-format
			J, JAL: immKind = sign11;
			default: immKind = sign5;
		endcase
	end

	// Extend the chosen field to full width
	always_comb begin
		case (immKind)
			zero5: immValue = {{(`DATA_W-5){1'b0}}, instr[4:0]};
			zero8: immValue = {{(`DATA_W-8){1'b0}}, instr[7:0]};
			sign8: immValue = {{(`DATA_W-8){instr[7]}}, instr[7:0]};
			sign11: immValue = {{(`DATA_W-11){instr[10]}}, instr[10:0]};
			default: immValue = {{(`DATA_W-5){instr[4]}}, instr[4:0]};
		endcase
	end

endmodule

// File: rtl/aluUnit.sv
// ####################
// ALU with its own opcode and funct decode
// ####################
`timescale 1ns/1ps
`include "exec_consts.svh"

module aluUnit (
	input  logic [`DATA_W-1:0] instr,
	input  logic [`DATA_W-1:0] regA,
	input  logic [`DATA_W-1:0] regB,
	input  logic [`DATA_W-1:0] immValue,
	output logic [`DATA_W-1:0] aluOut
);
	import execPkg::*;

	opcodeT opc;
	aluOpT aluOp;
	logic [1:0] funct;
	// Second operand comes from regB when set
	logic regSrc;
	logic [`DATA_W-1:0] opB;
	logic invA;
	logic [`DATA_W-1:0] addA;
	logic [`DATA_W-1:0] sum;
	logic [3:0] shAmt;
	logic [2*`DATA_W-1:0] rolWide;
	logic [2*`DATA_W-1:0] rorWide;
	logic eqRes;
	logic ltRes;

	assign opc = opcodeT'(instr[`DATA_W-1 -: `OPC_W]);
	assign funct = instr[1:0];

	// Operation and operand source decode
	always_comb begin
		aluOp = opAdd;
		regSrc = 1'b0;
		case (opc)
			ADDI: aluOp = opAdd;
			SUBI: aluOp = opSub;
			XORI: aluOp = opXor;
			ANDNI: aluOp = opAndn;
			ROLI: aluOp = opRol;
			SLLI: aluOp = opSll;
			RORI: aluOp = opRor;
			SRLI: aluOp = opSrl;
			ALU_RR: begin
				regSrc = 1'b1;
				// Funct order add, sub, xor, andn
				case (funct)
					2'b00: aluOp = opAdd;
					2'b01: aluOp = opSub;
					2'b10: aluOp = opXor;
					default: aluOp = opAndn;
				endcase
			end
			SHIFT_RR: begin
				regSrc = 1'b1;
				// Funct order rol, sll, ror, srl
				case (funct)
					2'b00: aluOp = opRol;
					2'b01: aluOp = opSll;
					2'b10: aluOp = opRor;
					default: aluOp = opSrl;
				endcase
			end
			SEQ: begin
				regSrc = 1'b1;
				aluOp = opEq;
			end
			SLT: begin
				regSrc = 1'b1;
				aluOp = opLt;
			end
			SLE: begin
				regSrc = 1'b1;
				aluOp = opLe;
			end
			LBI: aluOp = opPassB;
			SLBI: aluOp = opShiftLoad;
			// Branches, jumps and NOP leave the result unused
			default: aluOp = opAdd;
		endcase
	end

	assign opB = regSrc ? regB : immValue;

	// Subtract is opB minus regA by inverting A with carry in
	assign invA = (aluOp == opSub);
	assign addA = invA ? ~regA : regA;
	assign sum = opB + addA + {{(`DATA_W-1){1'b0}}, invA};

	// Shift amount is the low nibble of the second operand
	assign shAmt = opB[3:0];
	assign rolWide = {regA, regA} << shAmt;
	assign rorWide = {regA, regA} >> shAmt;

	// Signed compares of regA against opB
	assign eqRes = (regA == opB);
	assign ltRes = ($signed(regA) < $signed(opB));

	always_comb begin
		case (aluOp)
			opXor: aluOut = regA ^ opB;
			opAndn: aluOut = regA & ~opB;
			opRol: aluOut = rolWide[2*`DATA_W-1 -: `DATA_W];
			opSll: aluOut = regA << shAmt;
			opRor: aluOut = rorWide[`DATA_W-1:0];
			opSrl: aluOut = regA >> shAmt;
			opEq: aluOut = {{(`DATA_W-1){1'b0}}, eqRes};
			opLt: aluOut = {{(`DATA_W-1){1'b0}}, ltRes};
			opLe: aluOut = {{(`DATA_W-1){1'b0}}, ltRes | eqRes};
			opPassB: aluOut = opB;
			// Upper byte from regA, lower byte from the immediate
			opShiftLoad: aluOut = (regA << 8) | opB;
			// Add and sub share the adder
			default: aluOut = sum;
		endcase
	end

endmodule

// File: rtl/controlFlowUnit.sv
// ####################
// Branch test, jump decode and next PC
// ####################
`timescale 1ns/1ps
`include "exec_consts.svh"

module controlFlowUnit (
	input  logic [`DATA_W-1:0] instr,
	input  logic [`DATA_W-1:0] regA,
	input  logic [`DATA_W-1:0] pcNext,
	input  logic [`DATA_W-1:0] immValue,
	output logic [`DATA_W-1:0] nextPc,
	output logic taken,
	output logic linkWrite
);
	import execPkg::*;

	opcodeT opc;
	logic regZero;
	logic regNeg;
	logic branchHit;
	// PC-relative jump
	logic jumpImm;
	// Register-relative jump
	logic jumpReg;
	logic [`DATA_W-1:0] targetBase;
	logic [`DATA_W-1:0] target;

	assign opc = opcodeT'(instr[`DATA_W-1 -: `OPC_W]);

	// Conditions look at regA only
	assign regZero = (regA == '0);
	assign regNeg = regA[`DATA_W-1];

	always_comb begin
		branchHit = 1'b0;
		jumpImm = 1'b0;
		jumpReg = 1'b0;
		case (opc)
			BEQZ: branchHit = regZero;
			BNEZ: branchHit = ~regZero;
			BLTZ: branchHit = regNeg;
			// Zero counts as not negative
			BGEZ: branchHit = ~regNeg;
			J, JAL: jumpImm = 1'b1;
			JR, JALR: jumpReg = 1'b1;
			default: begin
				branchHit = 1'b0;
			end
		endcase
	end

	// One adder serves branches and both jump kinds
	assign targetBase = jumpReg ? regA : pcNext;
	assign target = targetBase + immValue;

	// Any redirect away from the fall-through address
	assign taken = branchHit | jumpImm | jumpReg;
	assign nextPc = taken ? target : pcNext;

	// Link register gets PC+2 on JAL and JALR
	assign linkWrite = (opc == JAL) || (opc == JALR);

endmodule

// File: rtl/resultMerge.sv
// ####################
// Write-back select and stage output register
// ####################
`timescale 1ns/1ps
`include "exec_consts.svh"

module resultMerge (
	input  logic clk,
	input  logic rst,
	input  execPkg::exInT exIn,
	input  logic [`DATA_W-1:0] aluOut,
	input  logic [`DATA_W-1:0] nextPc,
	input  logic taken,
	input  logic linkWrite,
	output execPkg::exResT exRes
);
	import execPkg::*;

	// Result assembled ahead of the register
	exResT resNext;

	always_comb begin
		// Link writes store the return address
		resNext.wbData = linkWrite ? exIn.pcNext : aluOut;
		resNext.nextPc = nextPc;
		resNext.taken = taken;
		resNext.linkWrite = linkWrite;
		// Valid follows the input strobe by one cycle
		resNext.vld = exIn.vld;
	end

	// Stage latch, loaded every cycle since there is no back-pressure
	always_ff @(posedge clk) begin
		if (rst) begin
			exRes <= '0;
		end else begin
			exRes <= resNext;
		end
	end

endmodule

// File: rtl/executeStage.sv
// ####################
// Execute stage top
// ####################
`timescale 1ns/1ps
`include "exec_consts.svh"

module executeStage (
	input  logic clk,
	input  logic rst,
	input  execPkg::exInT exIn,
	output execPkg::exResT exRes
);

	// Extended immediate shared by ALU and control flow
	logic [`DATA_W-1:0] immValue;
	logic [`DATA_W-1:0] aluOut;
	logic [`DATA_W-1:0] nextPc;
	logic taken;
	logic linkWrite;

	immExtend i_immExtend (
		.instr(exIn.instr),
		.immValue(immValue)
	);

	// Data path
	aluUnit i_aluUnit (
		.instr(exIn.instr),
		.regA(exIn.regA),
		.regB(exIn.regB),
		.immValue(immValue),
		.aluOut(aluOut)
	);

	// Control flow path, in parallel with the ALU
	controlFlowUnit i_controlFlowUnit (
		.instr(exIn.instr),
		.regA(exIn.regA),
		.pcNext(exIn.pcNext),
		.immValue(immValue),
		.nextPc(nextPc),
		.taken(taken),
		.linkWrite(linkWrite)
	);

	resultMerge i_resultMerge (
		.clk(clk),
		.rst(rst),
		.exIn(exIn),
		.aluOut(aluOut),
		.nextPc(nextPc),
		.taken(taken),
		.linkWrite(linkWrite),
		.exRes(exRes)
	);

endmodule

// File: sim/tbExecuteTests.svh
// ####################
// Reference model of the execute stage and directed tests
// ####################
`ifndef TB_EXECUTE_TESTS_SVH
`define TB_EXECUTE_TESTS_SVH

	// Immediate as the instruction formats define it
	function automatic logic [`DATA_W-1:0] extendImm(input logic [`DATA_W-1:0] ins);
		case (opcodeT'(ins[15:11]))
			XORI, ANDNI: return {11'b0, ins[4:0]};
			SLBI: return {8'b0, ins[7:0]};
			BEQZ, BNEZ, BLTZ, BGEZ, LBI, JR, JALR: return {{8{ins[7]}}, ins[7:0]};
			J, JAL: return {{5{ins[10]}}, ins[10:0]};
			default: return {{11{ins[4]}}, ins[4:0]};
		endcase
	endfunction

	function automatic logic [`DATA_W-1:0] computeAlu(input exInT v);
		opcodeT op;
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [3:0] n;
		logic [1:0] f;
		op = opcodeT'(v.instr[15:11]);
		a = v.regA;
		f = v.instr[1:0];
		case (op)
			ALU_RR, SHIFT_RR, SEQ, SLT, SLE: b = v.regB;
			default: b = extendImm(v.instr);
		endcase
		n = b[3:0];
		// Register groups behave like the matching immediate op
		if (op == ALU_RR)
			op = (f == 0) ? ADDI : (f == 1) ? SUBI : (f == 2) ? XORI : ANDNI;
		if (op == SHIFT_RR)
			op = (f == 0) ? ROLI : (f == 1) ? SLLI : (f == 2) ? RORI : SRLI;
		case (op)
			ADDI: return a + b;
			// Second operand minus regA
			SUBI: return b - a;
			XORI: return a ^ b;
			ANDNI: return a & ~b;
			ROLI: return (a << n) | (a >> (16 - n));
			SLLI: return a << n;
			RORI: return (a >> n) | (a << (16 - n));
			SRLI: return a >> n;
			SEQ: return {15'b0, a == b};
			SLT: return {15'b0, $signed(a) < $signed(b)};
			SLE: return {15'b0, $signed(a) <= $signed(b)};
			LBI: return b;
			SLBI: return {a[7:0], b[7:0]};
			default: return '0;
		endcase
	endfunction

	function automatic exResT predictResult(input exInT v);
		exResT r;
		opcodeT op;
		logic [`DATA_W-1:0] imm;
		logic [`DATA_W-1:0] target;
		op = opcodeT'(v.instr[15:11]);
		imm = extendImm(v.instr);
		target = v.pcNext + imm;
		r.taken = 1'b0;
		case (op)
			BEQZ: r.taken = (v.regA == 0);
			BNEZ: r.taken = (v.regA != 0);
			BLTZ: r.taken = v.regA[15];
			BGEZ: r.taken = !v.regA[15];
			J, JAL: r.taken = 1'b1;
			JR, JALR: begin
				r.taken = 1'b1;
				target = v.regA + imm;
			end
			default: ;
		endcase
		r.nextPc = r.taken ? target : v.pcNext;
		r.linkWrite = (op == JAL) || (op == JALR);
		r.wbData = r.linkWrite ? v.pcNext : computeAlu(v);
		r.vld = 1'b1;
		return r;
	endfunction

	// Branches, J, JR and NOP write nothing back
	function automatic bit writesBack(input opcodeT op);
		case (op)
			BEQZ, BNEZ, BLTZ, BGEZ, J, JR, NOP: return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

	task automatic sendRandom(input opcodeT op, input logic [1:0] funct, input int count);
		logic [`DATA_W-1:0] r;
		logic [`DATA_W-1:0] ins;
		repeat (count) begin
			r = nextRand();
			ins = {op, r[10:0]};
			if (op == ALU_RR || op == SHIFT_RR)
				ins[1:0] = funct;
			sendVec($sformatf("%s f%0d", op.name(), funct), ins, nextRand(), nextRand(),
				nextRand() & 16'hFFFE);
		end
	endtask

	// Both operands from the signed extremes
	task automatic sendEdges(input opcodeT op, input logic [1:0] funct);
		logic [`DATA_W-1:0] r;
		logic [`DATA_W-1:0] ins;
		for (int i = 0; i < 4; i++) begin
			r = nextRand();
			ins = {op, r[10:0]};
			if (op == ALU_RR || op == SHIFT_RR)
				ins[1:0] = funct;
			sendVec($sformatf("%s f%0d edge", op.name(), funct), ins,
				i[0] ? 16'h7FFF : 16'h8000, i[1] ? 16'h7FFF : 16'h8000, 16'h0100);
		end
	endtask

	task automatic drainResults();
		@(posedge clk);
		exIn.vld <= 1'b0;
		while (dueQ.size() > 0)
			@(negedge clk);
	endtask

	// A JAL strobe held through reset must not reach the output
	task automatic resetTest();
		exInT v;
		string nm;
		v = '0;
		v.instr = {JAL, 11'h010};
		v.pcNext = 16'h0040;
		v.vld = 1'b1;
		@(posedge clk);
		exIn <= v;
		for (int i = 0; i < 12; i++) begin
			if (i == 9) begin
				@(posedge clk);
				rst <= 1'b0;
				exIn <= '0;
			end
			@(negedge clk);
			nm = (i < 9) ? "during reset" : "after reset";
			checkFlag(nm, "vld", 1'b0, exRes.vld);
			checkFlag(nm, "taken", 1'b0, exRes.taken);
			checkFlag(nm, "linkWrite", 1'b0, exRes.linkWrite);
		end
	endtask

	// Back-to-back strobes, sign and zero extended immediates
	task automatic arithLogicTest();
		opcodeT immOps[4] = '{ADDI, SUBI, XORI, ANDNI};
		foreach (immOps[i])
			sendRandom(immOps[i], 2'b00, 40);
		for (int f = 0; f < 4; f++)
			sendRandom(ALU_RR, f[1:0], 40);
		drainResults();
	endtask

	task automatic shiftCompareTest();
		opcodeT ops[9] = '{SLLI, SRLI, ROLI, RORI, SEQ, SLT, SLE, LBI, SLBI};
		foreach (ops[i]) begin
			sendRandom(ops[i], 2'b00, 12);
			sendEdges(ops[i], 2'b00);
		end
		for (int f = 0; f < 4; f++) begin
			sendRandom(SHIFT_RR, f[1:0], 12);
			sendEdges(SHIFT_RR, f[1:0]);
		end
		drainResults();
	endtask

	// regA zero, positive and negative against both offset signs
	task automatic branchTest();
		opcodeT brOps[4] = '{BEQZ, BNEZ, BLTZ, BGEZ};
		opcodeT plainOps[4] = '{ADDI, XORI, LBI, NOP};
		logic [`DATA_W-1:0] aVals[3] = '{16'h0000, 16'h1234, 16'h8001};
		logic [7:0] offs[2] = '{8'h20, 8'hF0};
		opcodeT op;
		foreach (brOps[i]) begin
			op = brOps[i];
			foreach (aVals[j])
				foreach (offs[k])
					sendVec(op.name(), {op, 3'b000, offs[k]}, aVals[j], nextRand(),
						16'h2000 + 16'(4 * j));
		end
		// Fall-through for ordinary instructions
		foreach (plainOps[i])
			sendRandom(plainOps[i], 2'b00, 2);
		drainResults();
	endtask

	task automatic jumpTest();
		logic [10:0] off11[2] = '{11'h100, 11'h780};
		logic [7:0] off8[2] = '{8'h10, 8'hFC};
		string linkNm;
		linkNm = $sformatf("link r%0d", `LINK_REG);
		foreach (off11[k]) begin
			repeat (2) begin
				sendVec("J", {J, off11[k]}, nextRand(), nextRand(), nextRand() & 16'hFFFE);
				sendVec({"JAL ", linkNm}, {JAL, off11[k]}, nextRand(), nextRand(),
					nextRand() & 16'hFFFE);
				sendVec("JR", {JR, 3'b000, off8[k]}, nextRand(), nextRand(),
					nextRand() & 16'hFFFE);
				sendVec({"JALR ", linkNm}, {JALR, 3'b000, off8[k]}, nextRand(), nextRand(),
					nextRand() & 16'hFFFE);
			end
		end
		drainResults();
	endtask

`endif

// File: sim/tbExecute.sv
// ####################
// Execute stage testbench top
// Clock, reset, DUT, result checker, timeout and report
// ####################
`timescale 1ns/1ps
`include "exec_consts.svh"

module tbExecute;
	import execPkg::*;

	// Vectors over all tests, sets the cycle limit
	localparam int NUM_VEC = 576;
	localparam int TIMEOUT_CYC = NUM_VEC * 2 + 50;

	logic clk;
	logic rst;
	exInT exIn;
	exResT exRes;
	int cycleCnt;
	int errCnt;
	int checkCnt;
	int unsigned lcgState;
	// Expected results in the order they leave the stage
	exResT expQ[$];
	bit usedQ[$];
	string nameQ[$];
	int dueQ[$];

	executeStage i_dut (.clk(clk), .rst(rst), .exIn(exIn), .exRes(exRes));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCnt <= cycleCnt + 1;
	end

	// LCG for operands and immediate fields
	function automatic logic [`DATA_W-1:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[30:15];
	endfunction

	task automatic checkWord(input string name, input string field,
			input logic [`DATA_W-1:0] exp, input logic [`DATA_W-1:0] act);
		if (act !== exp) begin
			errCnt++;
			$display("Error %s %s: expected %h actual %h", name, field, exp, act);
		end
	endtask

	task automatic checkFlag(input string name, input string field,
			input logic exp, input logic act);
		if (act !== exp) begin
			errCnt++;
			$display("Error %s %s: expected %b actual %b", name, field, exp, act);
		end
	endtask

	// wbData is skipped where the instruction writes nothing back
	task automatic checkRes(input string name, input exResT exp, input exResT act,
			input bit used);
		checkCnt++;
		if (used)
			checkWord(name, "wbData", exp.wbData, act.wbData);
		checkWord(name, "nextPc", exp.nextPc, act.nextPc);
		checkFlag(name, "taken", exp.taken, act.taken);
		checkFlag(name, "linkWrite", exp.linkWrite, act.linkWrite);
	endtask

	`include "tbExecuteTests.svh"

	// Drive one instruction and queue its expected result
	task automatic sendVec(input string name, input logic [`DATA_W-1:0] ins,
			input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b,
			input logic [`DATA_W-1:0] pc);
		exInT v;
		v.instr = ins;
		v.regA = a;
		v.regB = b;
		v.pcNext = pc;
		v.vld = 1'b1;
		@(posedge clk);
		exIn <= v;
		expQ.push_back(predictResult(v));
		usedQ.push_back(writesBack(opcodeT'(ins[15:11])));
		nameQ.push_back(name);
		// Due at the falling edge after the next rising edge
		dueQ.push_back(cycleCnt + 2);
	endtask

	// Output checked mid-cycle, where the register is stable
	always @(negedge clk) begin
		if (dueQ.size() > 0 && dueQ[0] == cycleCnt) begin
			if (exRes.vld !== 1'b1) begin
				errCnt++;
				$display("No valid strobe one cycle after the input of %s", nameQ[0]);
			end else begin
				checkRes(nameQ[0], expQ[0], exRes, usedQ[0]);
			end
			expQ.delete(0);
			usedQ.delete(0);
			nameQ.delete(0);
			dueQ.delete(0);
		end else if (exRes.vld === 1'b1) begin
			errCnt++;
			$display("Valid strobe at cycle %0d with no input behind it", cycleCnt);
		end
	end

	initial begin
		wait (cycleCnt >= TIMEOUT_CYC);
		$display("Run stopped after %0d cycles with %0d results still outstanding",
			cycleCnt, dueQ.size());
		$display("Simulation failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		exIn = '0;
		cycleCnt = 0;
		errCnt = 0;
		checkCnt = 0;
		lcgState = 733;
		resetTest();
		arithLogicTest();
		shiftCompareTest();
		branchTest();
		jumpTest();
		$display("Results checked %0d, errors %0d", checkCnt, errCnt);
		if (errCnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+rtl
+incdir+sim
rtl/execPkg.sv
rtl/immExtend.sv
rtl/aluUnit.sv
rtl/controlFlowUnit.sv
rtl/resultMerge.sv
rtl/executeStage.sv
sim/tbExecute.sv
